// ==== design/rv_trap_params.svh ====
`ifndef RV_TRAP_PARAMS_SVH
`define RV_TRAP_PARAMS_SVH

// ######################################################################
// Datapath width.
// ######################################################################

`define XLEN 32

// ######################################################################
// Machine CSR numbers.
// ######################################################################

`define CSR_MTVEC  12'h305 // Trap vector base.
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342
`define CSR_MTVAL  12'h343
`define CSR_TDATA1 12'h7A1 // Bit 0 enables the breakpoint.
`define CSR_TDATA2 12'h7A2 // Breakpoint address.

// ######################################################################
// Exception cause codes.
// ######################################################################

`define MCAUSE_INST_MALIGN  0
`define MCAUSE_INST_FAULT   1
`define MCAUSE_INST_ILLEGAL 2
`define MCAUSE_BREAKPOINT   3 // Shared by ebreak and both breakpoint kinds.
`define MCAUSE_LOAD_MALIGN  4
`define MCAUSE_LOAD_FAULT   5
`define MCAUSE_STORE_MALIGN 6
`define MCAUSE_STORE_FAULT  7
`define MCAUSE_ENV_CALL     11

// ######################################################################
// Memory map.
// ######################################################################

// The only region that answers, base inclusive and limit exclusive.
`define MEM_BASE  32'h0000_1000
`define MEM_LIMIT 32'h0000_9000

`endif

// ==== design/rv_trap_pkg.sv ====
`include "rv_trap_params.svh"

package rv_trap_pkg;

    // ######################################################################
    // Vector types.
    // ######################################################################

    // Address, PC or CSR data.
    typedef logic [`XLEN-1:0] xlen_t;

    // CSR number as it appears in the instruction.
    typedef logic [11:0] csr_addr_t;

    // Access size.
    // 0 byte, 1 half, 2 word.
    typedef logic [1:0] mem_size_t;

    // ######################################################################
    // Sequencer states.
    // ######################################################################

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0, // Waiting for a step.
        SEQ_FETCH = 2'd1, // write_ir phase.
        SEQ_EXEC  = 2'd2  // write_pc phase.
    } seq_state_t;

endpackage

// ==== design/mem_check.sv ====
`timescale 1ns/1ps
`include "rv_trap_params.svh"

module mem_check (
    input  rv_trap_pkg::xlen_t     chk_addr,
    input  rv_trap_pkg::mem_size_t chk_size,
    input  logic                   chk_fetch,
    input  logic                   bkpt_en,
    input  rv_trap_pkg::xlen_t     bkpt_addr,
    output logic                   hit,
    output logic                   malign,
    output logic                   breakpoint
);
    import rv_trap_pkg::*;

    xlen_t           extent;    // Bytes past the first one.
    logic [`XLEN:0]  last_byte; // One bit wider so a wrap cannot fake a hit.

    always_comb begin
        unique case (chk_size)
            2'd0:    extent = xlen_t'(0);
            2'd1:    extent = xlen_t'(1);
            default: extent = xlen_t'(3);
        endcase
    end

    assign last_byte = {1'b0, chk_addr} + {1'b0, extent};

    // Both ends of the access must lie in the region.
    assign hit = (chk_addr >= `MEM_BASE)
              && (last_byte < {1'b0, `MEM_LIMIT});

    always_comb begin
        if (chk_fetch) begin
            malign = |chk_addr[1:0]; // Instructions are always word aligned.
        end else begin
            unique case (chk_size)
                2'd0:    malign = 1'b0;
                2'd1:    malign = chk_addr[0];
                default: malign = |chk_addr[1:0];
            endcase
        end
    end

    // Exact address match only.
    assign breakpoint = bkpt_en && (chk_addr == bkpt_addr);

endmodule

// ==== design/instr_seq.sv ====
`timescale 1ns/1ps

module instr_seq (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   step,
    input  rv_trap_pkg::xlen_t     pc,
    input  rv_trap_pkg::xlen_t     next_pc,
    input  rv_trap_pkg::xlen_t     mem_addr,
    input  rv_trap_pkg::mem_size_t mem_size,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   illegal,
    input  logic                   ecall,
    input  logic                   ebreak,
    input  logic                   trap,
    output logic                   busy,
    output logic                   done,
    output logic                   write_ir,
    output logic                   write_pc,
    output logic                   store,
    output logic                   is_mem,
    output logic                   illegal_q,
    output logic                   ecall_q,
    output logic                   ebreak_q,
    output rv_trap_pkg::xlen_t     pc_q,
    output rv_trap_pkg::xlen_t     next_pc_q,
    output rv_trap_pkg::xlen_t     mem_addr_q,
    output rv_trap_pkg::xlen_t     chk_addr,
    output rv_trap_pkg::mem_size_t chk_size,
    output logic                   chk_fetch
);
    import rv_trap_pkg::*;

    localparam mem_size_t SIZE_WORD = 2'd2;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       accept;
    logic       load_q;
    logic       store_q;
    mem_size_t  size_q;

    assign accept = step && (state == SEQ_IDLE); // Steps while busy are dropped.

    always_comb begin
        state_nxt = state;
        unique case (state)
            SEQ_IDLE:  if (accept) state_nxt = SEQ_FETCH;
            SEQ_FETCH: state_nxt = trap ? SEQ_IDLE : SEQ_EXEC; // Fetch trap skips EXEC.
            SEQ_EXEC:  state_nxt = SEQ_IDLE;
            default:   state_nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SEQ_IDLE;
            load_q    <= 1'b0;
            store_q   <= 1'b0;
            illegal_q <= 1'b0;
            ecall_q   <= 1'b0;
            ebreak_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                load_q    <= is_load;
                store_q   <= is_store;
                illegal_q <= illegal;
                ecall_q   <= ecall;
                ebreak_q  <= ebreak;
            end
        end
    end

    // Descriptor payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q       <= pc;
            next_pc_q  <= next_pc;
            mem_addr_q <= mem_addr;
            size_q     <= mem_size;
        end
    end

    assign busy     = (state != SEQ_IDLE);
    assign write_ir = (state == SEQ_FETCH);
    assign write_pc = (state == SEQ_EXEC);
    assign done     = (write_ir && trap) || write_pc;
    assign store    = store_q;
    assign is_mem   = load_q || store_q;

    // Address under check in each phase.
    always_comb begin
        chk_addr  = pc_q;
        chk_size  = SIZE_WORD;
        chk_fetch = 1'b1;
        if (write_pc) begin
            if (is_mem) begin
                chk_addr  = mem_addr_q;
                chk_size  = size_q;
                chk_fetch = 1'b0;
            end else begin
                chk_addr  = next_pc_q; // Branch target alignment.
            end
        end
    end

endmodule

// ==== design/int_ctl.sv ====
`timescale 1ns/1ps
`include "rv_trap_params.svh"

module int_ctl (
    input  logic               write_ir,
    input  logic               write_pc,
    input  logic               store,
    input  logic               is_mem,
    input  logic               breakpoint,
    input  logic               hit,
    input  logic               illegal,
    input  logic               malign,
    input  logic               ecall,
    input  logic               ebreak,
    input  rv_trap_pkg::xlen_t pc_q,
    input  rv_trap_pkg::xlen_t next_pc_q,
    input  rv_trap_pkg::xlen_t mem_addr_q,
    output rv_trap_pkg::xlen_t mcause_in,
    output rv_trap_pkg::xlen_t mtval_in,
    output logic               trap
);
    import rv_trap_pkg::*;

    // ######################################################################
    // Qualified conditions.
    // ######################################################################

    logic mem_phase;
    assign mem_phase = write_pc && is_mem; // Checker results refer to data.

    logic inst_breakpoint, inst_fault, inst_invalid, inst_align;
    logic env_call, env_break, ls_breakpoint;
    logic l_align, l_fault, s_align, s_fault;

    assign inst_breakpoint = breakpoint && write_ir;
    assign inst_fault      = !hit       && write_ir;
    assign inst_invalid    = illegal    && write_ir;
    assign inst_align      = malign     && write_pc && !is_mem; // next_pc target.
    assign env_call        = ecall      && write_pc;
    assign env_break       = ebreak     && write_pc;
    assign ls_breakpoint   = breakpoint && mem_phase;
    assign l_align         = malign     && mem_phase && !store;
    assign l_fault         = !hit       && mem_phase && !store;
    assign s_align         = malign     && mem_phase && store;
    assign s_fault         = !hit       && mem_phase && store;

    assign trap = inst_breakpoint || inst_fault || inst_invalid || inst_align
               || env_call || env_break || ls_breakpoint
               || l_align || l_fault || s_align || s_fault;

    // ######################################################################
    // Cause and trap value, highest priority first.
    // ######################################################################

    always_comb begin
        mcause_in = '0;
        mtval_in  = '0;
        if (inst_breakpoint) begin
            mcause_in = xlen_t'(`MCAUSE_BREAKPOINT);
            mtval_in  = pc_q;
        end else if (inst_fault) begin
            mcause_in = xlen_t'(`MCAUSE_INST_FAULT);
            mtval_in  = pc_q;
        end else if (inst_invalid) begin
            mcause_in = xlen_t'(`MCAUSE_INST_ILLEGAL);
            mtval_in  = pc_q;
        end else if (inst_align) begin
            mcause_in = xlen_t'(`MCAUSE_INST_MALIGN);
            mtval_in  = next_pc_q;
        end else if (env_call) begin
            mcause_in = xlen_t'(`MCAUSE_ENV_CALL);
            mtval_in  = pc_q;
        end else if (env_break) begin
            mcause_in = xlen_t'(`MCAUSE_BREAKPOINT);
            mtval_in  = pc_q;
        end else if (ls_breakpoint) begin
            mcause_in = xlen_t'(`MCAUSE_BREAKPOINT);
            mtval_in  = mem_addr_q;
        end else if (l_align) begin
            mcause_in = xlen_t'(`MCAUSE_LOAD_MALIGN);
            mtval_in  = mem_addr_q;
        end else if (l_fault) begin
            mcause_in = xlen_t'(`MCAUSE_LOAD_FAULT);
            mtval_in  = mem_addr_q;
        end else if (s_align) begin
            mcause_in = xlen_t'(`MCAUSE_STORE_MALIGN);
            mtval_in  = mem_addr_q;
        end else if (s_fault) begin
            mcause_in = xlen_t'(`MCAUSE_STORE_FAULT);
            mtval_in  = mem_addr_q;
        end
    end

endmodule

// ==== design/csr_regs.sv ====
`timescale 1ns/1ps
`include "rv_trap_params.svh"

module csr_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   csr_we,
    input  rv_trap_pkg::csr_addr_t csr_addr,
    input  rv_trap_pkg::xlen_t     csr_wdata,
    output rv_trap_pkg::xlen_t     csr_rdata,
    input  logic                   trap_we,
    input  rv_trap_pkg::xlen_t     mcause_in,
    input  rv_trap_pkg::xlen_t     mtval_in,
    input  rv_trap_pkg::xlen_t     epc,
    output rv_trap_pkg::xlen_t     ivec,
    output rv_trap_pkg::xlen_t     bkpt_addr,
    output logic                   bkpt_en
);
    import rv_trap_pkg::*;

    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t tdata1;
    xlen_t tdata2;

    // ######################################################################
    // Register updates.
    // ######################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
            tdata1 <= '0;
            tdata2 <= '0;
        end else begin
            if (csr_we) begin
                unique case (csr_addr)
                    `CSR_MTVEC:  mtvec  <= {csr_wdata[`XLEN-1:2], 2'b00}; // Direct mode only.
                    `CSR_MEPC:   mepc   <= csr_wdata;
                    `CSR_MCAUSE: mcause <= csr_wdata;
                    `CSR_MTVAL:  mtval  <= csr_wdata;
                    `CSR_TDATA1: tdata1 <= csr_wdata;
                    `CSR_TDATA2: tdata2 <= csr_wdata;
                    default: ;
                endcase
            end
            // Later assignment wins, so a trap overrides a software write.
            if (trap_we) begin
                mepc   <= epc;
                mcause <= mcause_in;
                mtval  <= mtval_in;
            end
        end
    end

    // ######################################################################
    // Read port and trigger outputs.
    // ######################################################################

    always_comb begin
        unique case (csr_addr)
            `CSR_MTVEC:  csr_rdata = mtvec;
            `CSR_MEPC:   csr_rdata = mepc;
            `CSR_MCAUSE: csr_rdata = mcause;
            `CSR_MTVAL:  csr_rdata = mtval;
            `CSR_TDATA1: csr_rdata = tdata1;
            `CSR_TDATA2: csr_rdata = tdata2;
            default:     csr_rdata = '0; // Unimplemented CSRs read zero.
        endcase
    end

    assign ivec      = {mtvec[`XLEN-1:2], 2'b00};
    assign bkpt_en   = tdata1[0];
    assign bkpt_addr = tdata2;

endmodule

// ==== design/rv_trap_top.sv ====
`timescale 1ns/1ps

module rv_trap_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   step,
    input  rv_trap_pkg::xlen_t     pc,
    input  rv_trap_pkg::xlen_t     next_pc,
    input  rv_trap_pkg::xlen_t     mem_addr,
    input  rv_trap_pkg::mem_size_t mem_size,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   illegal,
    input  logic                   ecall,
    input  logic                   ebreak,
    input  logic                   csr_we,
    input  rv_trap_pkg::csr_addr_t csr_addr,
    input  rv_trap_pkg::xlen_t     csr_wdata,
    output rv_trap_pkg::xlen_t     csr_rdata,
    output logic                   busy,
    output logic                   done,
    output logic                   trap,
    output rv_trap_pkg::xlen_t     ivec
);
    import rv_trap_pkg::*;

    // Sequencer outputs.
    logic      write_ir, write_pc, store, is_mem;
    logic      illegal_q, ecall_q, ebreak_q;
    xlen_t     pc_q, next_pc_q, mem_addr_q;
    xlen_t     chk_addr;
    mem_size_t chk_size;
    logic      chk_fetch;

    // Checker and CSR side.
    logic      hit, malign, breakpoint;
    logic      bkpt_en;
    xlen_t     bkpt_addr;
    xlen_t     mcause_in, mtval_in;

    instr_seq u_instr_seq (
        .clk, .arst_n, .step,
        .pc, .next_pc, .mem_addr, .mem_size,
        .is_load, .is_store, .illegal, .ecall, .ebreak,
        .trap, .busy, .done, .write_ir, .write_pc, .store, .is_mem,
        .illegal_q, .ecall_q, .ebreak_q,
        .pc_q, .next_pc_q, .mem_addr_q,
        .chk_addr, .chk_size, .chk_fetch
    );

    mem_check u_mem_check (
        .chk_addr, .chk_size, .chk_fetch,
        .bkpt_en, .bkpt_addr,
        .hit, .malign, .breakpoint
    );

    int_ctl u_int_ctl (
        .write_ir, .write_pc, .store, .is_mem,
        .breakpoint, .hit, .malign,
        .illegal (illegal_q),
        .ecall   (ecall_q),
        .ebreak  (ebreak_q),
        .pc_q, .next_pc_q, .mem_addr_q,
        .mcause_in, .mtval_in, .trap
    );

    csr_regs u_csr_regs (
        .clk, .arst_n,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .trap_we (trap),
        .mcause_in, .mtval_in,
        .epc     (pc_q), // Faulting instruction address.
        .ivec, .bkpt_addr, .bkpt_en
    );

endmodule

// ==== test/rv_trap_tb.sv ====
`timescale 1ns/1ps
`include "rv_trap_params.svh"

module rv_trap_tb;
    import rv_trap_pkg::*;

    localparam int NUM_INSTR    = 400;
    localparam int CSR_ROUNDS   = 24;
    localparam int INSTR_CYCLES = 16; // Issue, two phases, collision, readback, trigger setup.
    localparam int TIMEOUT_CYCLES =
        10 * (NUM_INSTR * INSTR_CYCLES + CSR_ROUNDS * 18 + 200);

    logic      clk, arst_n, step;
    xlen_t     pc, next_pc, mem_addr;
    mem_size_t mem_size;
    logic      is_load, is_store, illegal, ecall, ebreak;
    logic      csr_we;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata, csr_rdata;
    logic      busy, done, trap;
    xlen_t     ivec;

    // Current descriptor.
    xlen_t     d_pc, d_next_pc, d_mem_addr;
    mem_size_t d_size;
    logic      d_load, d_store, d_illegal, d_ecall, d_ebreak;

    // Expected CSR contents.
    xlen_t m_mtvec, m_mepc, m_mcause, m_mtval, m_tdata1, m_tdata2;

    rv_trap_top u_rv_trap_top (
        .clk, .arst_n, .step,
        .pc, .next_pc, .mem_addr, .mem_size,
        .is_load, .is_store, .illegal, .ecall, .ebreak,
        .csr_we, .csr_addr, .csr_wdata, .csr_rdata,
        .busy, .done, .trap, .ivec
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("Watchdog expired before all tests finished.");
    end

    // ######################################################################
    // Checks.
    // ######################################################################

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ######################################################################
    // Reference model.
    // ######################################################################

    // First and last byte must both fall inside the region.
    function automatic logic in_region(input xlen_t addr, input mem_size_t size);
        logic [`XLEN:0] last;
        last = {1'b0, addr} + ((size == 2'd0) ? 33'd0 : (size == 2'd1) ? 33'd1 : 33'd3);
        return (addr >= `MEM_BASE) && (last < {1'b0, `MEM_LIMIT});
    endfunction

    function automatic logic misaligned(input xlen_t addr, input mem_size_t size);
        case (size)
            2'd0:    return 1'b0;
            2'd1:    return addr[0];
            default: return |addr[1:0];
        endcase
    endfunction

    task automatic predict_trap(output logic t, output int lat, output xlen_t cause,
                                output xlen_t tval);
        logic f_bp, is_mem, bad_align, outside, ls_bp;
        f_bp  = m_tdata1[0] && (d_pc == m_tdata2);
        t     = 1'b1;
        lat   = 1;
        cause = '0;
        tval  = d_pc;
        if (f_bp) cause = `MCAUSE_BREAKPOINT;
        else if (!in_region(d_pc, 2'd2)) cause = `MCAUSE_INST_FAULT;
        else if (d_illegal) cause = `MCAUSE_INST_ILLEGAL;
        else begin
            lat       = 2;
            is_mem    = d_load || d_store;
            bad_align = is_mem ? misaligned(d_mem_addr, d_size) : misaligned(d_next_pc, 2'd2);
            outside   = !in_region(d_mem_addr, d_size);
            ls_bp     = m_tdata1[0] && (d_mem_addr == m_tdata2);
            if (!is_mem && bad_align) begin
                cause = `MCAUSE_INST_MALIGN;
                tval  = d_next_pc;
            end else if (d_ecall) cause = `MCAUSE_ENV_CALL;
            else if (d_ebreak) cause = `MCAUSE_BREAKPOINT;
            else if (!is_mem) t = 1'b0;
            else begin
                tval = d_mem_addr; // All remaining causes report the data address.
                if (ls_bp) cause = `MCAUSE_BREAKPOINT;
                else if (bad_align) cause = d_store ? `MCAUSE_STORE_MALIGN : `MCAUSE_LOAD_MALIGN;
                else if (outside) cause = d_store ? `MCAUSE_STORE_FAULT : `MCAUSE_LOAD_FAULT;
                else t = 1'b0;
            end
        end
    endtask

    // ######################################################################
    // Stimulus.
    // ######################################################################

    task automatic csr_write(input csr_addr_t a, input xlen_t d);
        @(negedge clk);
        csr_we    = 1'b1;
        csr_addr  = a;
        csr_wdata = d;
        case (a)
            `CSR_MTVEC:  m_mtvec  = {d[`XLEN-1:2], 2'b00};
            `CSR_MEPC:   m_mepc   = d;
            `CSR_MCAUSE: m_mcause = d;
            `CSR_MTVAL:  m_mtval  = d;
            `CSR_TDATA1: m_tdata1 = d;
            `CSR_TDATA2: m_tdata2 = d;
            default: ;
        endcase
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic check_csr(input string name, input csr_addr_t a, input xlen_t exp);
        @(negedge clk);
        csr_addr = a;
        @(negedge clk);
        check_xlen(name, exp, csr_rdata);
    endtask

    task automatic check_all_csrs();
        xlen_t r;
        r = $urandom;
        check_csr("mtvec", `CSR_MTVEC, m_mtvec);
        check_csr("mepc", `CSR_MEPC, m_mepc);
        check_csr("mcause", `CSR_MCAUSE, m_mcause);
        check_csr("mtval", `CSR_MTVAL, m_mtval);
        check_csr("tdata1", `CSR_TDATA1, m_tdata1);
        check_csr("tdata2", `CSR_TDATA2, m_tdata2);
        check_csr("unknown csr", {4'hB, r[7:0]}, '0); // Counter space is not implemented.
    endtask

    function automatic xlen_t pick_addr();
        xlen_t a;
        int    r;
        r = $urandom % 16;
        if (r < 11) a = `MEM_BASE + ($urandom % (`MEM_LIMIT - `MEM_BASE));
        else if (r < 13) a = `MEM_LIMIT - 32'd1 - ($urandom % 4); // Straddles the limit.
        else if (r < 14) a = `MEM_BASE - ($urandom % 2);
        else a = $urandom;
        if ($urandom % 2) a[1:0] = 2'b00;
        return a;
    endfunction

    task automatic make_descriptor();
        int kind;
        d_pc       = pick_addr();
        d_next_pc  = ($urandom % 2) ? d_pc + 32'd4 : pick_addr();
        d_mem_addr = pick_addr();
        d_size     = mem_size_t'($urandom % 3);
        kind       = $urandom % 3;
        d_load     = (kind == 1);
        d_store    = (kind == 2);
        d_illegal  = ($urandom % 16) == 0;
        d_ecall    = ($urandom % 16) == 0;
        d_ebreak   = ($urandom % 16) == 0;
    endtask

    task automatic clean_descriptor();
        d_pc       = `MEM_BASE + 32'h100;
        d_next_pc  = d_pc + 32'd4;
        d_mem_addr = `MEM_BASE + 32'h200;
        d_size     = 2'd2;
        {d_load, d_store, d_illegal, d_ecall, d_ebreak} = '0;
    endtask

    // Garbage on the inputs while the sequencer is busy.
    task automatic drive_noise();
        xlen_t r;
        r        = $urandom;
        step     = 1'b1;
        pc       = $urandom;
        next_pc  = $urandom;
        mem_addr = $urandom;
        mem_size = r[1:0];
        {is_load, is_store, illegal, ecall, ebreak} = r[6:2];
    endtask

    task automatic run_instr(input logic poke, input logic collide);
        logic  exp_trap;
        int    exp_lat;
        int    cycles;
        xlen_t exp_cause, exp_tval;
        predict_trap(exp_trap, exp_lat, exp_cause, exp_tval);
        @(negedge clk);
        {step, pc, next_pc, mem_addr, mem_size} = {1'b1, d_pc, d_next_pc, d_mem_addr, d_size};
        {is_load, is_store, illegal, ecall, ebreak} =
            {d_load, d_store, d_illegal, d_ecall, d_ebreak};
        csr_we = 1'b0;
        @(negedge clk);
        cycles = 1;
        while (!done) begin
            check_bit("busy in flight", 1'b1, busy);
            if (cycles == 2) fail_run("done did not rise within two cycles of a step.");
            if (poke) drive_noise();
            else step = 1'b0;
            @(negedge clk);
            cycles++;
        end
        check_xlen("latency", xlen_t'(exp_lat), xlen_t'(cycles));
        check_bit("trap at done", exp_trap, trap);
        if (exp_trap) check_xlen("trap vector", {m_mtvec[`XLEN-1:2], 2'b00}, ivec);
        step = 1'b0;
        if (collide) begin
            csr_we    = 1'b1;
            csr_addr  = `CSR_MCAUSE;
            csr_wdata = $urandom;
            m_mcause  = csr_wdata; // Overwritten below when the instruction traps.
        end
        if (exp_trap) begin
            m_mepc   = d_pc;
            m_mcause = exp_cause;
            m_mtval  = exp_tval;
        end
        @(negedge clk);
        csr_we = 1'b0;
        check_bit("busy after done", 1'b0, busy);
        check_bit("done after done", 1'b0, done);
        check_bit("trap when idle", 1'b0, trap);
        check_csr("mepc after instruction", `CSR_MEPC, m_mepc);
        check_csr("mcause after instruction", `CSR_MCAUSE, m_mcause);
        check_csr("mtval after instruction", `CSR_MTVAL, m_mtval);
    endtask

    // ######################################################################
    // Test sequence.
    // ######################################################################

    initial begin
        xlen_t     r;
        csr_addr_t a;
        void'($urandom(32'h9f788978));
        {arst_n, step, pc, next_pc, mem_addr, mem_size} = '0;
        {is_load, is_store, illegal, ecall, ebreak} = '0;
        {csr_we, csr_addr, csr_wdata} = '0;
        {m_mtvec, m_mepc, m_mcause, m_mtval, m_tdata1, m_tdata2} = '0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        check_bit("busy after reset", 1'b0, busy);
        check_bit("done after reset", 1'b0, done);
        check_bit("trap after reset", 1'b0, trap);
        check_all_csrs();
        for (int i = 0; i < CSR_ROUNDS; i++) begin
            r = $urandom;
            case (r[2:0])
                3'd0:    a = `CSR_MTVEC;
                3'd1:    a = `CSR_MEPC;
                3'd2:    a = `CSR_MCAUSE;
                3'd3:    a = `CSR_MTVAL;
                3'd4:    a = `CSR_TDATA1;
                3'd5:    a = `CSR_TDATA2;
                default: a = {4'hB, r[15:8]};
            endcase
            csr_write(a, $urandom);
            check_all_csrs();
        end
        csr_write(`CSR_TDATA1, '0);
        csr_write(`CSR_MTVEC, $urandom);

        // Breakpoints on the fetch PC and on load and store addresses.
        clean_descriptor();
        csr_write(`CSR_TDATA2, d_pc);
        csr_write(`CSR_TDATA1, 32'd1);
        run_instr(1'b0, 1'b0);
        check_csr("fetch breakpoint cause", `CSR_MCAUSE, 32'd3);
        d_load = 1'b1;
        csr_write(`CSR_TDATA2, d_mem_addr);
        run_instr(1'b0, 1'b0);
        check_csr("load breakpoint cause", `CSR_MCAUSE, 32'd3);
        check_csr("load breakpoint value", `CSR_MTVAL, d_mem_addr);
        {d_load, d_store} = 2'b01;
        run_instr(1'b0, 1'b0);
        check_csr("store breakpoint cause", `CSR_MCAUSE, 32'd3);
        csr_write(`CSR_TDATA1, '0);
        csr_write(`CSR_MCAUSE, '0);
        run_instr(1'b0, 1'b0);
        check_csr("disabled breakpoint", `CSR_MCAUSE, '0);

        // Steps while busy, then a software write racing a trap.
        run_instr(1'b1, 1'b0);
        d_illegal = 1'b1;
        run_instr(1'b0, 1'b1);
        check_csr("collision cause", `CSR_MCAUSE, 32'd2);

        for (int i = 0; i < NUM_INSTR; i++) begin
            make_descriptor();
            r = $urandom;
            if (r[2:0] == 3'd0) begin
                csr_write(`CSR_TDATA2, r[3] ? d_pc : d_mem_addr);
                csr_write(`CSR_TDATA1, xlen_t'(r[4]));
            end
            run_instr(r[6:5] == 2'd0, r[10:7] == 4'd0);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== rv_trap.f ====
+incdir+design
design/rv_trap_pkg.sv
design/mem_check.sv
design/instr_seq.sv
design/int_ctl.sv
design/csr_regs.sv
design/rv_trap_top.sv
test/rv_trap_tb.sv

// ==== Makefile ====
# Verilator build and run for the trap path testbench.

VERILATOR ?= verilator
TOP       ?= rv_trap_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing
FILELIST  ?= rv_trap.f
LOG       ?= sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -qx "TESTS PASSED" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
